// File: files.f
source/conv_pkg.sv
source/sram_arbiter.sv
source/patch_fetch.sv
source/weight_fetch.sv
source/conv_sequencer.sv
source/mac_operand_pack.sv
source/conv_feeder.sv
verification/sram_model.sv
verification/conv_feeder_tb.sv

// File: Makefile
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	verilator --binary -Wno-fatal --top-module conv_feeder_tb -f files.f -o conv_feeder_sim
	./obj_dir/conv_feeder_sim | tee /dev/stderr | grep -qx "No errors"

clean:
	rm -rf obj_dir

// File: verification/conv_feeder_tb.sv
`timescale 1ns/1ps

module conv_feeder_tb import conv_pkg::*; ();

    localparam int          MAX_GROUPS       = 8;
    localparam int          MEM_BYTES        = 4096;
    localparam logic [31:0] SEED             = 32'hfb746de2;
    localparam int          CYCLES_PER_ISSUE = 200;
    localparam int          MARGIN_CYCLES    = 1000;

    logic clk = 1'b0;
    logic rst;
    logic start;
    dim_t img_row, img_col, ker_row, ker_col;
    dim_t in_ch, out_ch, stride_row, stride_col;
    addr_t img_base, w_base;

    logic  mem_req;
    addr_t mem_addr;
    word_t mem_rdata;

    logic                      busy, done, ready;
    mac_vec_t                  data_mac, weight_mac;
    dim_t                      num_groups;
    mac_cnt_t [MAX_GROUPS-1:0] num_macs;
    dim_t                      conv_row, conv_col, oc_base;

    // one entry per expected issue in visit order
    mac_vec_t exp_data_q[$];
    mac_vec_t exp_weight_q[$];
    dim_t     exp_groups_q[$];
    mac_cnt_t exp_total_q[$];
    dim_t     exp_row_q[$];
    dim_t     exp_col_q[$];
    dim_t     exp_oc_q[$];

    int   errors     = 0;
    int   checks     = 0;
    int   cyc        = 0;
    int   budget_cyc = MARGIN_CYCLES;
    logic job_active = 1'b0;

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    conv_feeder #(.MAX_GROUPS(MAX_GROUPS)) uut (
        .clk(clk), .rst(rst), .start_i(start),
        .img_row_i(img_row), .img_col_i(img_col),
        .ker_row_i(ker_row), .ker_col_i(ker_col),
        .in_ch_i(in_ch), .out_ch_i(out_ch),
        .stride_row_i(stride_row), .stride_col_i(stride_col),
        .img_base_i(img_base), .w_base_i(w_base),
        .mem_req_o(mem_req), .mem_addr_o(mem_addr), .mem_rdata_i(mem_rdata),
        .busy_o(busy), .done_o(done), .mac_data_ready_o(ready),
        .data_mac_o(data_mac), .weight_mac_o(weight_mac),
        .num_groups_o(num_groups), .num_macs_o(num_macs),
        .conv_row_o(conv_row), .conv_col_o(conv_col), .oc_base_o(oc_base)
    );

    sram_model #(.DEPTH(MEM_BYTES), .SEED(SEED)) sram (
        .clk(clk), .req_i(mem_req), .addr_i(mem_addr), .rdata_o(mem_rdata)
    );

    task automatic check_vec(input string name, input mac_vec_t expected, input mac_vec_t actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("ERROR %s expected %h got %h", name, expected, actual);
        end
    endtask

    task automatic check_cnt(input string name, input mac_cnt_t expected, input mac_cnt_t actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("ERROR %s expected %h got %h", name, expected, actual);
        end
    endtask

    task automatic check_dim(input string name, input dim_t expected, input dim_t actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("ERROR %s expected %h got %h", name, expected, actual);
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("ERROR %s expected %h got %h", name, expected, actual);
        end
    endtask

    function automatic logic [DATA_W-1:0] mem_byte(input int addr);
        return sram.mem_q[addr % MEM_BYTES];
    endfunction

    task automatic clear_expected();
        exp_data_q.delete();
        exp_weight_q.delete();
        exp_groups_q.delete();
        exp_total_q.delete();
        exp_row_q.delete();
        exp_col_q.delete();
        exp_oc_q.delete();
    endtask

    // reference model for the layout, output size and packing rules
    task automatic build_expected(input int ir, input int icl, input int kr, input int kc,
                                  input int ic, input int oc, input int sr, input int sc,
                                  input int ib, input int wb, output int n);
        int       total;
        int       out_rows;
        int       out_cols;
        int       fit;
        int       grp;
        int       base;
        int       r;
        int       c;
        int       krow;
        int       rest;
        int       addr;
        mac_vec_t dv;
        mac_vec_t wv;
        n        = 0;
        total    = kr * kc * ic;
        out_rows = (ir - kr) / sr + 1;
        out_cols = (icl - kc) / sc + 1;
        fit      = MAC_BYTES / total;
        if (fit > MAX_GROUPS) begin
            fit = MAX_GROUPS;
        end
        // columns outer, rows middle, channel groups inner
        for (int ocol = 0; ocol < out_cols; ocol++) begin
            for (int orow = 0; orow < out_rows; orow++) begin
                base = 0;
                while (base < oc) begin
                    grp = (oc - base < fit) ? oc - base : fit;
                    r   = orow * sr;
                    c   = ocol * sc;
                    dv  = '0;
                    wv  = '0;
                    for (int g = 0; g < grp; g++) begin
                        for (int j = 0; j < total; j++) begin
                            krow = j / (kc * ic);
                            rest = j % (kc * ic);
                            addr = ib + ((r + krow) * icl + c + rest / ic) * ic + rest % ic;
                            dv[(g * total + j) * DATA_W +: DATA_W] = mem_byte(addr);
                            wv[(g * total + j) * DATA_W +: DATA_W] =
                                mem_byte(wb + (base + g) * total + j);
                        end
                    end
                    exp_data_q.push_back(dv);
                    exp_weight_q.push_back(wv);
                    exp_groups_q.push_back(dim_t'(grp));
                    exp_total_q.push_back(mac_cnt_t'(total));
                    exp_row_q.push_back(dim_t'(r));
                    exp_col_q.push_back(dim_t'(c));
                    exp_oc_q.push_back(dim_t'(base));
                    base += grp;
                    n++;
                end
            end
        end
    endtask

    task automatic compare_issue();
        dim_t     exp_groups;
        mac_cnt_t exp_total;
        mac_cnt_t exp_macs;
        if (exp_data_q.size() == 0) begin
            errors++;
            $display("extra issue at row %0d col %0d oc %0d, none was expected",
                     conv_row, conv_col, oc_base);
        end else begin
            exp_groups = exp_groups_q.pop_front();
            exp_total  = exp_total_q.pop_front();
            check_dim("conv_row_o", exp_row_q.pop_front(), conv_row);
            check_dim("conv_col_o", exp_col_q.pop_front(), conv_col);
            check_dim("oc_base_o", exp_oc_q.pop_front(), oc_base);
            check_dim("num_groups_o", exp_groups, num_groups);
            check_vec("data_mac_o", exp_data_q.pop_front(), data_mac);
            check_vec("weight_mac_o", exp_weight_q.pop_front(), weight_mac);
            for (int g = 0; g < MAX_GROUPS; g++) begin
                exp_macs = (g < exp_groups) ? exp_total : '0;
                check_cnt($sformatf("num_macs_o[%0d]", g), exp_macs, num_macs[g]);
            end
        end
    endtask

    task automatic drive_job(input int ir, input int icl, input int kr, input int kc,
                             input int ic, input int oc, input int sr, input int sc,
                             input int ib, input int wb);
        img_row    = dim_t'(ir);
        img_col    = dim_t'(icl);
        ker_row    = dim_t'(kr);
        ker_col    = dim_t'(kc);
        in_ch      = dim_t'(ic);
        out_ch     = dim_t'(oc);
        stride_row = dim_t'(sr);
        stride_col = dim_t'(sc);
        img_base   = addr_t'(ib);
        w_base     = addr_t'(wb);
    endtask

    task automatic run_job(input int ir, input int icl, input int kr, input int kc,
                           input int ic, input int oc, input int sr, input int sc,
                           input int ib, input int wb, output int seen);
        int   n;
        logic dropped;
        seen    = 0;
        dropped = 1'b0;
        build_expected(ir, icl, kr, kc, ic, oc, sr, sc, ib, wb, n);
        budget_cyc += n * CYCLES_PER_ISSUE;
        @(negedge clk);
        drive_job(ir, icl, kr, kc, ic, oc, sr, sc, ib, wb);
        start      = 1'b1;
        job_active = 1'b1;
        @(negedge clk);
        start = 1'b0;
        while (!done) begin
            if (ready) begin
                compare_issue();
                seen++;
            end
            if (!busy && !dropped) begin
                errors++;
                dropped = 1'b1;
                $display("busy_o went low while the job was still running");
            end
            @(negedge clk);
        end
        if (ready) begin
            compare_issue();
            seen++;
        end
        // busy ends in the done cycle
        check_bit("busy_o", 1'b0, busy);
        if (exp_data_q.size() != 0) begin
            errors++;
            $display("done_o came early, %0d issue(s) never arrived", exp_data_q.size());
            clear_expected();
        end
        job_active = 1'b0;
    endtask

    task automatic apply_reset();
        @(negedge clk);
        rst = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b1;
    endtask

    // 1x1 kernel gives groups of 8, 8 and 4
    task automatic pointwise_groups();
        int seen;
        run_job(3, 3, 1, 1, 4, 20, 1, 1, 'h100, 'h400, seen);
    endtask

    // 27 MACs per kernel so two kernels share a vector
    task automatic kernel3x3_groups();
        int seen;
        run_job(4, 4, 3, 3, 3, 5, 1, 1, 'h200, 'h500, seen);
    endtask

    task automatic stride2_order();
        int seen;
        run_job(7, 6, 3, 3, 2, 3, 2, 2, 'h300, 'h600, seen);
        // 3 output rows by 2 output columns
        if (seen != 6) begin
            errors++;
            $display("stride test saw %0d issues instead of 6", seen);
        end
    endtask

    // one kernel fills all 64 bytes
    task automatic full_vector();
        int seen;
        run_job(5, 5, 4, 4, 4, 2, 1, 1, 'h700, 'h800, seen);
    endtask

    // a job cut short by reset must leave the DUT idle
    task automatic idle_and_back_to_back();
        int seen;
        @(negedge clk);
        drive_job(4, 4, 2, 2, 2, 3, 1, 1, 'h900, 'hc00);
        start      = 1'b1;
        job_active = 1'b1;
        @(negedge clk);
        start = 1'b0;
        check_bit("busy_o", 1'b1, busy);
        check_bit("mem_req_o", 1'b1, mem_req);
        apply_reset();
        job_active = 1'b0;
        repeat (4) begin
            @(negedge clk);
            check_bit("busy_o", 1'b0, busy);
            check_bit("done_o", 1'b0, done);
            check_bit("mac_data_ready_o", 1'b0, ready);
            check_bit("mem_req_o", 1'b0, mem_req);
        end
        run_job(4, 4, 2, 2, 2, 3, 1, 1, 'h900, 'hc00, seen);
        run_job(4, 4, 2, 2, 2, 3, 1, 1, 'ha40, 'hc00, seen);
    endtask

    // no issue may show up between jobs
    always @(negedge clk) begin
        if (ready && !job_active) begin
            errors++;
            $display("extra issue at time %0t outside of any job", $time);
        end
    end

    initial begin
        while (cyc <= budget_cyc) begin
            @(posedge clk);
        end
        errors++;
        $display("timeout after %0d cycles, the DUT never finished", cyc);
        $display("checks %0d, errors %0d", checks, errors);
        $display("Errors found");
        $finish;
    end

    initial begin
        rst        = 1'b0;
        start      = 1'b0;
        img_row    = '0;
        img_col    = '0;
        ker_row    = '0;
        ker_col    = '0;
        in_ch      = '0;
        out_ch     = '0;
        stride_row = '0;
        stride_col = '0;
        img_base   = '0;
        w_base     = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b1;

        pointwise_groups();
        kernel3x3_groups();
        stride2_order();
        full_vector();
        idle_and_back_to_back();

        repeat (2) @(negedge clk);
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// File: verification/sram_model.sv
`timescale 1ns/1ps

module sram_model import conv_pkg::*; #(
    parameter int          DEPTH = 4096,
    parameter logic [31:0] SEED  = 32'h1
) (
    input  logic  clk,
    input  logic  req_i,
    input  addr_t addr_i,
    output word_t rdata_o
);

    logic [DATA_W-1:0] mem_q [DEPTH];
    integer            seed;

    // random contents, reproducible through the seed
    initial begin
        seed = SEED;
        for (int a = 0; a < DEPTH; a++) begin
            mem_q[a] = DATA_W'($random(seed));
        end
    end

    // eight bytes from any byte address, one cycle after the request
    always_ff @(posedge clk) begin
        if (req_i) begin
            for (int k = 0; k < WORD_BYTES; k++) begin
                rdata_o[k * DATA_W +: DATA_W] <= mem_q[(int'(addr_i) + k) % DEPTH];
            end
        end
    end

endmodule

// File: source/conv_feeder.sv
`timescale 1ns/1ps

module conv_feeder import conv_pkg::*; #(
    parameter int MAX_GROUPS = 8
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       start_i,
    input  dim_t                       img_row_i,
    input  dim_t                       img_col_i,
    input  dim_t                       ker_row_i,
    input  dim_t                       ker_col_i,
    input  dim_t                       in_ch_i,
    input  dim_t                       out_ch_i,
    input  dim_t                       stride_row_i,
    input  dim_t                       stride_col_i,
    input  addr_t                      img_base_i,
    input  addr_t                      w_base_i,
    output logic                       mem_req_o,
    output addr_t                      mem_addr_o,
    input  word_t                      mem_rdata_i,
    output logic                       busy_o,
    output logic                       done_o,
    output logic                       mac_data_ready_o,
    output mac_vec_t                   data_mac_o,
    output mac_vec_t                   weight_mac_o,
    output dim_t                       num_groups_o,
    output mac_cnt_t [MAX_GROUPS-1:0]  num_macs_o,
    output dim_t                       conv_row_o,
    output dim_t                       conv_col_o,
    output dim_t                       oc_base_o
);

    logic     patch_start, weight_start;
    logic     patch_done, weight_done;
    dim_t     org_row, org_col, oc_base, groups;
    addr_t    w_addr, patch_addr, weight_addr;
    mac_cnt_t w_bytes, total_macs;
    logic     load;
    logic     patch_req, weight_req, patch_gnt, weight_gnt;
    logic     patch_valid, weight_valid;
    word_t    rdata;
    mac_vec_t patch_buf, weight_buf;

    conv_sequencer #(.MAX_GROUPS(MAX_GROUPS)) u_seq (
        .clk(clk), .rst(rst), .start_i(start_i),
        .img_row_i(img_row_i), .img_col_i(img_col_i),
        .ker_row_i(ker_row_i), .ker_col_i(ker_col_i),
        .in_ch_i(in_ch_i), .out_ch_i(out_ch_i),
        .stride_row_i(stride_row_i), .stride_col_i(stride_col_i),
        .w_base_i(w_base_i),
        .patch_start_o(patch_start), .weight_start_o(weight_start),
        .org_row_o(org_row), .org_col_o(org_col),
        .w_addr_o(w_addr), .w_bytes_o(w_bytes),
        .patch_done_i(patch_done), .weight_done_i(weight_done),
        .load_o(load), .groups_o(groups), .total_macs_o(total_macs),
        .oc_base_o(oc_base), .busy_o(busy_o), .done_o(done_o)
    );

    patch_fetch u_patch (
        .clk(clk), .rst(rst), .start_i(patch_start),
        .org_row_i(org_row), .org_col_i(org_col), .img_col_i(img_col_i),
        .ker_row_i(ker_row_i), .ker_col_i(ker_col_i), .in_ch_i(in_ch_i),
        .img_base_i(img_base_i),
        .req_o(patch_req), .addr_o(patch_addr),
        .gnt_i(patch_gnt), .valid_i(patch_valid), .rdata_i(rdata),
        .done_o(patch_done), .patch_o(patch_buf)
    );

    weight_fetch u_weight (
        .clk(clk), .rst(rst), .start_i(weight_start),
        .base_i(w_addr), .bytes_i(w_bytes),
        .req_o(weight_req), .addr_o(weight_addr),
        .gnt_i(weight_gnt), .valid_i(weight_valid), .rdata_i(rdata),
        .done_o(weight_done), .weights_o(weight_buf)
    );

    sram_arbiter u_arb (
        .clk(clk), .rst(rst),
        .patch_req_i(patch_req), .weight_req_i(weight_req),
        .patch_addr_i(patch_addr), .weight_addr_i(weight_addr),
        .patch_gnt_o(patch_gnt), .weight_gnt_o(weight_gnt),
        .patch_valid_o(patch_valid), .weight_valid_o(weight_valid),
        .rdata_o(rdata),
        .mem_req_o(mem_req_o), .mem_addr_o(mem_addr_o), .mem_rdata_i(mem_rdata_i)
    );

    mac_operand_pack #(.MAX_GROUPS(MAX_GROUPS)) u_pack (
        .clk(clk), .rst(rst), .load_i(load),
        .groups_i(groups), .total_macs_i(total_macs),
        .patch_i(patch_buf), .weights_i(weight_buf),
        .row_i(org_row), .col_i(org_col), .oc_base_i(oc_base),
        .data_mac_o(data_mac_o), .weight_mac_o(weight_mac_o),
        .num_groups_o(num_groups_o), .num_macs_o(num_macs_o),
        .conv_row_o(conv_row_o), .conv_col_o(conv_col_o), .oc_base_o(oc_base_o),
        .mac_data_ready_o(mac_data_ready_o)
    );

endmodule

// File: source/mac_operand_pack.sv
`timescale 1ns/1ps

module mac_operand_pack import conv_pkg::*; #(
    parameter int MAX_GROUPS = 8
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       load_i,
    input  dim_t                       groups_i,
    input  mac_cnt_t                   total_macs_i,
    input  mac_vec_t                   patch_i,
    input  mac_vec_t                   weights_i,
    input  dim_t                       row_i,
    input  dim_t                       col_i,
    input  dim_t                       oc_base_i,
    output mac_vec_t                   data_mac_o,
    output mac_vec_t                   weight_mac_o,
    output dim_t                       num_groups_o,
    output mac_cnt_t [MAX_GROUPS-1:0]  num_macs_o,
    output dim_t                       conv_row_o,
    output dim_t                       conv_col_o,
    output dim_t                       oc_base_o,
    output logic                       mac_data_ready_o
);

    mac_vec_t                  data_pack;
    mac_vec_t                  weight_pack;
    mac_cnt_t [MAX_GROUPS-1:0] macs_pack;
    logic                      ready_q;

    always_comb begin
        data_pack   = '0;
        weight_pack = '0;
        // one copy of the patch per used group
        for (int g = 0; g < MAX_GROUPS; g++) begin
            macs_pack[g] = (g < groups_i) ? total_macs_i : '0;
            for (int j = 0; j < MAC_BYTES; j++) begin
                if (g < groups_i && j < total_macs_i && g * total_macs_i + j < MAC_BYTES) begin
                    data_pack[(g * total_macs_i + j) * DATA_W +: DATA_W] =
                        patch_i[j * DATA_W +: DATA_W];
                end
            end
        end
        // weights are already packed, just mask the tail
        for (int b = 0; b < MAC_BYTES; b++) begin
            if (b < groups_i * total_macs_i) begin
                weight_pack[b * DATA_W +: DATA_W] = weights_i[b * DATA_W +: DATA_W];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load_i) begin
            data_mac_o   <= data_pack;
            weight_mac_o <= weight_pack;
            num_groups_o <= groups_i;
            num_macs_o   <= macs_pack;
            conv_row_o   <= row_i;
            conv_col_o   <= col_i;
            oc_base_o    <= oc_base_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            ready_q <= 1'b0;
        end else begin
            ready_q <= load_i;
        end
    end

    assign mac_data_ready_o = ready_q;

endmodule

// File: source/conv_sequencer.sv
`timescale 1ns/1ps

module conv_sequencer import conv_pkg::*; #(
    parameter int MAX_GROUPS = 8
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     start_i,
    input  dim_t     img_row_i,
    input  dim_t     img_col_i,
    input  dim_t     ker_row_i,
    input  dim_t     ker_col_i,
    input  dim_t     in_ch_i,
    input  dim_t     out_ch_i,
    input  dim_t     stride_row_i,
    input  dim_t     stride_col_i,
    input  addr_t    w_base_i,
    output logic     patch_start_o,
    output logic     weight_start_o,
    output dim_t     org_row_o,
    output dim_t     org_col_o,
    output addr_t    w_addr_o,
    output mac_cnt_t w_bytes_o,
    input  logic     patch_done_i,
    input  logic     weight_done_i,
    output logic     load_o,
    output dim_t     groups_o,
    output mac_cnt_t total_macs_o,
    output dim_t     oc_base_o,
    output logic     busy_o,
    output logic     done_o
);

    seq_state_t state_q;
    dim_t       org_row_q;
    dim_t       org_col_q;
    dim_t       oc_base_q;
    logic       done_q;

    mac_cnt_t total_macs;
    dim_t     fit;
    dim_t     remain;
    dim_t     grp;
    dim_t     row_lim;
    dim_t     col_lim;
    logic     more_groups;
    logic     more_rows;
    logic     more_cols;
    logic     job_start;

    assign total_macs = mac_cnt_t'(ker_row_i * ker_col_i * in_ch_i);

    // how many kernels fit side by side in one MAC vector
    always_comb begin
        fit = 8'd1;
        for (int g = 1; g <= MAX_GROUPS; g++) begin
            if (g * total_macs <= MAC_BYTES) begin
                fit = dim_t'(g);
            end
        end
    end

    assign remain = out_ch_i - oc_base_q;
    assign grp    = (remain < fit) ? remain : fit;

    // last valid origin, same as (img - ker) / stride + 1 positions
    assign row_lim = img_row_i - ker_row_i;
    assign col_lim = img_col_i - ker_col_i;

    assign more_groups = 9'(oc_base_q) + 9'(grp) < 9'(out_ch_i);
    assign more_rows   = 9'(org_row_q) + 9'(stride_row_i) <= 9'(row_lim);
    assign more_cols   = 9'(org_col_q) + 9'(stride_col_i) <= 9'(col_lim);

    assign job_start = state_q == SEQ_IDLE && start_i;

    // patch is refetched only on a new position
    assign patch_start_o  = job_start ||
                            (state_q == SEQ_NEXT && !more_groups && (more_rows || more_cols));
    assign weight_start_o = job_start ||
                            (state_q == SEQ_NEXT && (more_groups || more_rows || more_cols));

    always_ff @(posedge clk) begin
        if (!rst) begin
            state_q   <= SEQ_IDLE;
            org_row_q <= '0;
            org_col_q <= '0;
            oc_base_q <= '0;
            done_q    <= 1'b0;
        end else begin
            done_q <= 1'b0;
            case (state_q)
                SEQ_IDLE: begin
                    if (start_i) begin
                        org_row_q <= '0;
                        org_col_q <= '0;
                        oc_base_q <= '0;
                        state_q   <= SEQ_FETCH;
                    end
                end
                SEQ_FETCH: begin
                    if (patch_done_i && weight_done_i) begin
                        state_q <= SEQ_ISSUE;
                    end
                end
                SEQ_ISSUE: begin
                    state_q <= SEQ_NEXT;
                end
                default: begin
                    // channel groups, then rows, then columns
                    state_q <= SEQ_FETCH;
                    if (more_groups) begin
                        oc_base_q <= oc_base_q + grp;
                    end else if (more_rows) begin
                        oc_base_q <= '0;
                        org_row_q <= org_row_q + stride_row_i;
                    end else if (more_cols) begin
                        oc_base_q <= '0;
                        org_row_q <= '0;
                        org_col_q <= org_col_q + stride_col_i;
                    end else begin
                        done_q  <= 1'b1;
                        state_q <= SEQ_IDLE;
                    end
                end
            endcase
        end
    end

    assign org_row_o    = org_row_q;
    assign org_col_o    = org_col_q;
    assign oc_base_o    = oc_base_q;
    assign w_addr_o     = w_base_i + oc_base_q * total_macs;
    assign w_bytes_o    = mac_cnt_t'(grp * total_macs);
    assign groups_o     = grp;
    assign total_macs_o = total_macs;
    assign load_o       = state_q == SEQ_ISSUE;
    assign busy_o       = state_q != SEQ_IDLE;
    assign done_o       = done_q;

endmodule

// File: source/weight_fetch.sv
`timescale 1ns/1ps

module weight_fetch import conv_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     start_i,
    input  addr_t    base_i,
    input  mac_cnt_t bytes_i,
    output logic     req_o,
    output addr_t    addr_o,
    input  logic     gnt_i,
    input  logic     valid_i,
    input  word_t    rdata_i,
    output logic     done_o,
    output mac_vec_t weights_o
);

    logic     req_q;
    logic     done_q;
    mac_cnt_t cnt_q;
    mac_vec_t wbuf_q;

    mac_cnt_t left;
    mac_cnt_t chunk;

    // last word of the group is clipped
    assign left   = bytes_i - cnt_q;
    assign chunk  = (left > mac_cnt_t'(WORD_BYTES)) ? mac_cnt_t'(WORD_BYTES) : left;
    assign addr_o = base_i + cnt_q;

    always_ff @(posedge clk) begin
        if (!rst) begin
            req_q  <= 1'b0;
            done_q <= 1'b0;
            cnt_q  <= '0;
        end else if (start_i) begin
            req_q  <= 1'b1;
            done_q <= 1'b0;
            cnt_q  <= '0;
        end else begin
            if (gnt_i) begin
                req_q <= 1'b0;
            end
            if (valid_i) begin
                cnt_q <= cnt_q + chunk;
                if (chunk == left) begin
                    done_q <= 1'b1;
                end else begin
                    req_q <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start_i) begin
            wbuf_q <= '0;
        end else if (valid_i) begin
            for (int k = 0; k < WORD_BYTES; k++) begin
                if (k < chunk && cnt_q + k < MAC_BYTES) begin
                    wbuf_q[(cnt_q + k) * DATA_W +: DATA_W] <= rdata_i[k * DATA_W +: DATA_W];
                end
            end
        end
    end

    assign req_o     = req_q;
    assign done_o    = done_q;
    assign weights_o = wbuf_q;

endmodule

// File: source/patch_fetch.sv
`timescale 1ns/1ps

module patch_fetch import conv_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     start_i,
    input  dim_t     org_row_i,
    input  dim_t     org_col_i,
    input  dim_t     img_col_i,
    input  dim_t     ker_row_i,
    input  dim_t     ker_col_i,
    input  dim_t     in_ch_i,
    input  addr_t    img_base_i,
    output logic     req_o,
    output addr_t    addr_o,
    input  logic     gnt_i,
    input  logic     valid_i,
    input  word_t    rdata_i,
    output logic     done_o,
    output mac_vec_t patch_o
);

    logic     req_q;
    logic     done_q;
    dim_t     kr_q;
    mac_cnt_t run_off_q;
    mac_cnt_t buf_off_q;
    mac_vec_t patch_q;

    mac_cnt_t run_len;
    mac_cnt_t run_left;
    mac_cnt_t chunk;
    addr_t    pix_row;

    // one kernel row is a contiguous run in channel-last layout
    assign run_len  = mac_cnt_t'(ker_col_i * in_ch_i);
    assign run_left = run_len - run_off_q;
    assign chunk    = (run_left > mac_cnt_t'(WORD_BYTES)) ? mac_cnt_t'(WORD_BYTES) : run_left;

    assign pix_row = addr_t'(org_row_i) + addr_t'(kr_q);
    assign addr_o  = img_base_i + (pix_row * img_col_i + org_col_i) * in_ch_i + run_off_q;

    always_ff @(posedge clk) begin
        if (!rst) begin
            req_q     <= 1'b0;
            done_q    <= 1'b0;
            kr_q      <= '0;
            run_off_q <= '0;
            buf_off_q <= '0;
        end else if (start_i) begin
            req_q     <= 1'b1;
            done_q    <= 1'b0;
            kr_q      <= '0;
            run_off_q <= '0;
            buf_off_q <= '0;
        end else begin
            if (gnt_i) begin
                req_q <= 1'b0;
            end
            if (valid_i) begin
                buf_off_q <= buf_off_q + chunk;
                if (chunk == run_left) begin
                    // end of this kernel row
                    run_off_q <= '0;
                    kr_q      <= kr_q + 8'd1;
                    if (kr_q == ker_row_i - 8'd1) begin
                        done_q <= 1'b1;
                    end else begin
                        req_q <= 1'b1;
                    end
                end else begin
                    run_off_q <= run_off_q + chunk;
                    req_q     <= 1'b1;
                end
            end
        end
    end

    // keep only the bytes of the run
    always_ff @(posedge clk) begin
        if (valid_i) begin
            for (int k = 0; k < WORD_BYTES; k++) begin
                if (k < chunk && buf_off_q + k < MAC_BYTES) begin
                    patch_q[(buf_off_q + k) * DATA_W +: DATA_W] <= rdata_i[k * DATA_W +: DATA_W];
                end
            end
        end
    end

    assign req_o   = req_q;
    assign done_o  = done_q;
    assign patch_o = patch_q;

endmodule

// File: source/sram_arbiter.sv
`timescale 1ns/1ps

module sram_arbiter import conv_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  logic   patch_req_i,
    input  logic   weight_req_i,
    input  addr_t  patch_addr_i,
    input  addr_t  weight_addr_i,
    output logic   patch_gnt_o,
    output logic   weight_gnt_o,
    output logic   patch_valid_o,
    output logic   weight_valid_o,
    output word_t  rdata_o,
    output logic   mem_req_o,
    output addr_t  mem_addr_o,
    input  word_t  mem_rdata_i
);

    arb_owner_t owner_q;
    logic       pend_q;
    logic       patch_pick;

    // on a tie the side that did not win last time goes first
    assign patch_pick   = patch_req_i && (!weight_req_i || owner_q == OWN_WEIGHT);
    assign patch_gnt_o  = patch_pick;
    assign weight_gnt_o = weight_req_i && !patch_pick;

    assign mem_req_o  = patch_req_i || weight_req_i;
    assign mem_addr_o = patch_pick ? patch_addr_i : weight_addr_i;

    always_ff @(posedge clk) begin
        if (!rst) begin
            owner_q <= OWN_WEIGHT;
            pend_q  <= 1'b0;
        end else begin
            pend_q <= mem_req_o;
            if (mem_req_o) begin
                owner_q <= patch_pick ? OWN_PATCH : OWN_WEIGHT;
            end
        end
    end

    // word returns one cycle after the grant
    assign patch_valid_o  = pend_q && owner_q == OWN_PATCH;
    assign weight_valid_o = pend_q && owner_q == OWN_WEIGHT;
    assign rdata_o        = mem_rdata_i;

endmodule

// File: source/conv_pkg.sv
package conv_pkg;

    // byte and word geometry
    localparam int DATA_W     = 8;
    localparam int WORD_BYTES = 8;
    localparam int MAC_BYTES  = 64;

    localparam int ADDR_W    = 16;
    localparam int DIM_W     = 8;
    // must hold the value 64
    localparam int MAC_CNT_W = 7;

    typedef logic [ADDR_W-1:0]              addr_t;
    typedef logic [DIM_W-1:0]               dim_t;
    // byte k sits at bits 8k+7 down to 8k
    typedef logic [WORD_BYTES*DATA_W-1:0]   word_t;
    typedef logic [MAC_BYTES*DATA_W-1:0]    mac_vec_t;
    typedef logic [MAC_CNT_W-1:0]           mac_cnt_t;

    typedef enum logic [1:0] {
        SEQ_IDLE,
        SEQ_FETCH,
        SEQ_ISSUE,
        SEQ_NEXT
    } seq_state_t;

    // owner of the read in flight
    typedef enum logic {
        OWN_PATCH,
        OWN_WEIGHT
    } arb_owner_t;

endpackage
